// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_jump_predict_top
FILELIST  := jump_predict_top.f
OBJ_DIR   := obj_dir
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/direction_table.sv ====
module direction_table #(
    parameter int INDEX_BITS = 5
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc,
    output predictor_pkg::counter_e       o_counter,
    table_update_if.sink                  upd
);

    localparam int ENTRIES = 1 << INDEX_BITS;

    predictor_pkg::counter_e counters_q [ENTRIES];

    logic [INDEX_BITS-1:0] rd_idx;
    logic [INDEX_BITS-1:0] wr_idx;
    logic                  wr_en;

    function automatic predictor_pkg::counter_e step_counter(
        input predictor_pkg::counter_e c,
        input logic                    taken
    );
        predictor_pkg::counter_e n;
        n = c;
        case (c)
            predictor_pkg::STRONG_NT: n = taken ? predictor_pkg::WEAK_NT  : predictor_pkg::STRONG_NT;
            predictor_pkg::WEAK_NT:   n = taken ? predictor_pkg::WEAK_T   : predictor_pkg::STRONG_NT;
            predictor_pkg::WEAK_T:    n = taken ? predictor_pkg::STRONG_T : predictor_pkg::WEAK_NT;
            predictor_pkg::STRONG_T:  n = taken ? predictor_pkg::STRONG_T : predictor_pkg::WEAK_T;
            default:                  n = predictor_pkg::COUNTER_INIT;
        endcase
        return n;
    endfunction

    assign rd_idx = i_pc[predictor_pkg::INDEX_LSB +: INDEX_BITS];
    assign wr_idx = upd.update_pc[predictor_pkg::INDEX_LSB +: INDEX_BITS];
    assign wr_en  = upd.update_valid && upd.update_is_branch;

    assign o_counter = counters_q[rd_idx];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters_q[i] <= predictor_pkg::COUNTER_INIT;
            end
        end else if (wr_en) begin
            counters_q[wr_idx] <= step_counter(counters_q[wr_idx], upd.update_taken);
        end
    end

    // Non-branch resolutions are JAL or JALR and always taken
    a_jump_update_taken: assert property (@(posedge clk) disable iff (i_reset)
        (upd.update_valid && !upd.update_is_branch) |-> upd.update_taken);

endmodule

// ==== hw/ex_jump_handler.sv ====
module ex_jump_handler (
    input  logic                          i_stall,
    input  logic                          i_valid,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc4,
    input  rv_types_pkg::ir_type_e        i_ir_type,
    input  logic                          i_prediction,
    input  logic [rv_types_pkg::XLEN-1:0] i_addr_prediction,
    input  logic                          i_ex_taken,
    input  logic [rv_types_pkg::XLEN-1:0] i_ex_target,
    output logic                          o_jump,
    output logic [rv_types_pkg::XLEN-1:0] o_jump_addr,
    table_update_if.source                upd
);

    logic active;
    logic is_branch;
    logic real_taken;
    logic dir_wrong;
    logic addr_wrong;

    // Resolve only valid control transfers that are not held by a stall
    assign active    = i_valid && rv_types_pkg::is_jump(i_ir_type) && !i_stall;
    assign is_branch = (i_ir_type == rv_types_pkg::IR_BRANCH);

    // JAL and JALR always transfer control
    assign real_taken = is_branch ? i_ex_taken : 1'b1;

    assign dir_wrong  = (real_taken != i_prediction);
    assign addr_wrong = real_taken && i_prediction && (i_ex_target != i_addr_prediction);

    always_comb begin
        o_jump      = active && (dir_wrong || addr_wrong);
        o_jump_addr = real_taken ? i_ex_target : i_pc4;
    end

    // Train both tables with every resolution
    assign upd.update_valid     = active;
    assign upd.update_pc        = i_pc;
    assign upd.update_target    = i_ex_target;
    assign upd.update_taken     = real_taken;
    assign upd.update_is_branch = is_branch;

endmodule

// ==== hw/ir_type_converter.sv ====
module ir_type_converter (
    input  logic [rv_types_pkg::XLEN-1:0] i_ir,
    output rv_types_pkg::ir_type_e        o_ir_type
);

    rv_types_pkg::opcode_e opcode;
    logic [2:0]            funct3;

    assign opcode = rv_types_pkg::opcode_e'(i_ir[6:0]);
    assign funct3 = i_ir[14:12];

    always_comb begin
        case (opcode)
            rv_types_pkg::OPC_BRANCH: begin
                o_ir_type = rv_types_pkg::IR_BRANCH;
            end
            rv_types_pkg::OPC_JAL: begin
                o_ir_type = rv_types_pkg::IR_JAL;
            end
            rv_types_pkg::OPC_JALR: begin
                // Only funct3 000 is defined for JALR
                if (funct3 == 3'b000) begin
                    o_ir_type = rv_types_pkg::IR_JALR;
                end else begin
                    o_ir_type = rv_types_pkg::IR_ILLEGAL;
                end
            end
            rv_types_pkg::OPC_OP,
            rv_types_pkg::OPC_OP_IMM,
            rv_types_pkg::OPC_LOAD,
            rv_types_pkg::OPC_STORE,
            rv_types_pkg::OPC_LUI,
            rv_types_pkg::OPC_AUIPC,
            rv_types_pkg::OPC_SYSTEM: begin
                o_ir_type = rv_types_pkg::IR_OTHER;
            end
            default: begin
                o_ir_type = rv_types_pkg::IR_ILLEGAL;
            end
        endcase
    end

endmodule

// ==== hw/jump_predict_top.sv ====
module jump_predict_top #(
    parameter int INDEX_BITS = 5
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_stall,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc_if,
    input  logic [rv_types_pkg::XLEN-1:0] i_ir_if,
    input  logic                          i_ex_taken,
    input  logic [rv_types_pkg::XLEN-1:0] i_ex_target,
    output logic                          o_jump_prediction,
    output logic [rv_types_pkg::XLEN-1:0] o_addr_prediction,
    output logic                          o_jump,
    output logic [rv_types_pkg::XLEN-1:0] o_jump_addr
);

    rv_types_pkg::ir_type_e        ir_type_if;

    // ID/EX record
    logic                          valid_ex;
    logic [rv_types_pkg::XLEN-1:0] pc_ex;
    logic [rv_types_pkg::XLEN-1:0] pc4_ex;
    rv_types_pkg::ir_type_e        ir_type_ex;
    logic                          prediction_ex;
    logic [rv_types_pkg::XLEN-1:0] addr_prediction_ex;

    table_update_if upd_if ();

    ir_type_converter ir_type_converter_inst (
        .i_ir      (i_ir_if),
        .o_ir_type (ir_type_if)
    );

    jump_predictor #(.INDEX_BITS(INDEX_BITS)) jump_predictor_inst (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_pc_if           (i_pc_if),
        .i_ir_type_if      (ir_type_if),
        .o_jump_prediction (o_jump_prediction),
        .o_addr_prediction (o_addr_prediction),
        .upd               (upd_if.sink)
    );

    prediction_pipe prediction_pipe_inst (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_stall           (i_stall),
        .i_flush           (o_jump),
        .i_pc              (i_pc_if),
        .i_ir_type         (ir_type_if),
        .i_prediction      (o_jump_prediction),
        .i_addr_prediction (o_addr_prediction),
        .o_valid           (valid_ex),
        .o_pc              (pc_ex),
        .o_pc4             (pc4_ex),
        .o_ir_type         (ir_type_ex),
        .o_prediction      (prediction_ex),
        .o_addr_prediction (addr_prediction_ex)
    );

    ex_jump_handler ex_jump_handler_inst (
        .i_stall           (i_stall),
        .i_valid           (valid_ex),
        .i_pc              (pc_ex),
        .i_pc4             (pc4_ex),
        .i_ir_type         (ir_type_ex),
        .i_prediction      (prediction_ex),
        .i_addr_prediction (addr_prediction_ex),
        .i_ex_taken        (i_ex_taken),
        .i_ex_target       (i_ex_target),
        .o_jump            (o_jump),
        .o_jump_addr       (o_jump_addr),
        .upd               (upd_if.source)
    );

endmodule

// ==== hw/jump_predictor.sv ====
module jump_predictor #(
    parameter int INDEX_BITS = 5
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc_if,
    input  rv_types_pkg::ir_type_e        i_ir_type_if,
    output logic                          o_jump_prediction,
    output logic [rv_types_pkg::XLEN-1:0] o_addr_prediction,
    table_update_if.sink                  upd
);

    logic                          target_hit;
    logic [rv_types_pkg::XLEN-1:0] target_addr;
    logic [rv_types_pkg::XLEN-1:0] pc4;
    predictor_pkg::counter_e       counter;

    target_table #(.INDEX_BITS(INDEX_BITS)) target_table_inst (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_pc     (i_pc_if),
        .o_hit    (target_hit),
        .o_target (target_addr),
        .upd      (upd)
    );

    direction_table #(.INDEX_BITS(INDEX_BITS)) direction_table_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_pc      (i_pc_if),
        .o_counter (counter),
        .upd       (upd)
    );

    assign pc4 = i_pc_if + 32'd4;

    always_comb begin
        case (i_ir_type_if)
            rv_types_pkg::IR_JAL,
            rv_types_pkg::IR_JALR:   o_jump_prediction = target_hit;
            // Branches also need the counter to lean taken
            rv_types_pkg::IR_BRANCH: o_jump_prediction = target_hit &&
                                                         predictor_pkg::counter_taken(counter);
            default:                 o_jump_prediction = 1'b0;
        endcase
    end

    assign o_addr_prediction = o_jump_prediction ? target_addr : pc4;

endmodule

// ==== hw/prediction_pipe.sv ====
module prediction_pipe (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_stall,
    input  logic                          i_flush,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc,
    input  rv_types_pkg::ir_type_e        i_ir_type,
    input  logic                          i_prediction,
    input  logic [rv_types_pkg::XLEN-1:0] i_addr_prediction,
    output logic                          o_valid,
    output logic [rv_types_pkg::XLEN-1:0] o_pc,
    output logic [rv_types_pkg::XLEN-1:0] o_pc4,
    output rv_types_pkg::ir_type_e        o_ir_type,
    output logic                          o_prediction,
    output logic [rv_types_pkg::XLEN-1:0] o_addr_prediction
);

    // IF/ID stage
    logic                          ifid_valid;
    logic [rv_types_pkg::XLEN-1:0] ifid_pc;
    logic [rv_types_pkg::XLEN-1:0] ifid_pc4;
    rv_types_pkg::ir_type_e        ifid_ir_type;
    logic                          ifid_prediction;
    logic [rv_types_pkg::XLEN-1:0] ifid_addr_prediction;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ifid_valid <= 1'b0;
            o_valid    <= 1'b0;
        end else if (!i_stall) begin
            // A redirect kills both younger instructions
            ifid_valid <= !i_flush;
            o_valid    <= ifid_valid && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            ifid_pc              <= i_pc;
            ifid_pc4             <= i_pc + 32'd4;
            ifid_ir_type         <= i_ir_type;
            ifid_prediction      <= i_prediction;
            ifid_addr_prediction <= i_addr_prediction;
            o_pc                 <= ifid_pc;
            o_pc4                <= ifid_pc4;
            o_ir_type            <= ifid_ir_type;
            o_prediction         <= ifid_prediction;
            o_addr_prediction    <= ifid_addr_prediction;
        end
    end

    a_no_stall_in_reset: assert property (@(posedge clk) i_reset |-> !i_stall);

endmodule

// ==== hw/predictor_pkg.sv ====
package predictor_pkg;

    // 2-bit saturating direction counter
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_e;

    localparam counter_e COUNTER_INIT = WEAK_NT;

    // Word aligned fetch, so the two low PC bits carry no index information
    localparam int INDEX_LSB = 2;

    // First PC bit above the index
    function automatic int tag_lsb(input int index_bits);
        return INDEX_LSB + index_bits;
    endfunction

    // Everything above the index goes into the tag
    function automatic int tag_bits(input int index_bits);
        return rv_types_pkg::XLEN - tag_lsb(index_bits);
    endfunction

    function automatic logic counter_taken(input counter_e c);
        return (c == WEAK_T) || (c == STRONG_T);
    endfunction

endpackage

// ==== hw/rv_types_pkg.sv ====
package rv_types_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        IR_OTHER   = 4'd0,
        IR_BRANCH  = 4'd1,
        IR_JAL     = 4'd2,
        IR_JALR    = 4'd3,
        IR_ILLEGAL = 4'd4
    } ir_type_e;

    // Control transfer types that go through resolution
    function automatic logic is_jump(input ir_type_e t);
        return (t == IR_BRANCH) || (t == IR_JAL) || (t == IR_JALR);
    endfunction

endpackage

// ==== hw/table_update_if.sv ====
interface table_update_if;

    logic                            update_valid;
    logic [rv_types_pkg::XLEN-1:0]   update_pc;
    logic [rv_types_pkg::XLEN-1:0]   update_target;
    logic                            update_taken;
    logic                            update_is_branch;

    modport source (
        output update_valid,
        output update_pc,
        output update_target,
        output update_taken,
        output update_is_branch
    );

    modport sink (
        input update_valid,
        input update_pc,
        input update_target,
        input update_taken,
        input update_is_branch
    );

endinterface

// ==== hw/target_table.sv ====
module target_table #(
    parameter int INDEX_BITS = 5
) (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic [rv_types_pkg::XLEN-1:0] i_pc,
    output logic                          o_hit,
    output logic [rv_types_pkg::XLEN-1:0] o_target,
    table_update_if.sink                  upd
);

    localparam int ENTRIES  = 1 << INDEX_BITS;
    localparam int TAG_LSB  = predictor_pkg::tag_lsb(INDEX_BITS);
    localparam int TAG_BITS = predictor_pkg::tag_bits(INDEX_BITS);

    logic [ENTRIES-1:0]                valid_q;
    logic [TAG_BITS-1:0]               tag_q    [ENTRIES];
    logic [rv_types_pkg::XLEN-1:0]     target_q [ENTRIES];

    logic [INDEX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0]   rd_tag;
    logic [INDEX_BITS-1:0] wr_idx;
    logic [TAG_BITS-1:0]   wr_tag;
    logic                  wr_en;

    assign rd_idx = i_pc[predictor_pkg::INDEX_LSB +: INDEX_BITS];
    assign rd_tag = i_pc[rv_types_pkg::XLEN-1:TAG_LSB];
    assign wr_idx = upd.update_pc[predictor_pkg::INDEX_LSB +: INDEX_BITS];
    assign wr_tag = upd.update_pc[rv_types_pkg::XLEN-1:TAG_LSB];

    // Only taken outcomes teach a target
    assign wr_en = upd.update_valid && upd.update_taken;

    assign o_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign o_target = target_q[rd_idx];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.update_target;
        end
    end

    // Resolved targets come from the execute stage and must be word aligned
    a_target_aligned: assert property (@(posedge clk) disable iff (i_reset)
        wr_en |-> (upd.update_target[1:0] == 2'b00));

endmodule

// ==== jump_predict_top.f ====
hw/rv_types_pkg.sv
hw/predictor_pkg.sv
hw/table_update_if.sv
hw/ir_type_converter.sv
hw/target_table.sv
hw/direction_table.sv
hw/jump_predictor.sv
hw/prediction_pipe.sv
hw/ex_jump_handler.sv
hw/jump_predict_top.sv
verification/tb_jump_predict_top.sv

// ==== verification/tb_jump_predict_top.sv ====
module tb_jump_predict_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INDEX_BITS   = 5;
    localparam int ENTRIES      = 1 << INDEX_BITS;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 3000;
    localparam int DRIVE_DELAY  = 2;

    // Several PCs share an index with different tags
    localparam logic [31:0] PC_SET [8] = '{32'h0000_1000, 32'h0000_1004, 32'h0000_1008,
        32'h0000_1010, 32'h0000_2000, 32'h0000_2004, 32'h0000_1080, 32'h0000_3010};
    localparam logic [31:0] TARGET_SET [4] = '{32'h0000_4000, 32'h0000_4040,
        32'h0000_5000, 32'h0000_1008};

    typedef struct packed {
        logic                   valid;
        logic [31:0]            pc;
        logic [31:0]            pc4;
        rv_types_pkg::ir_type_e ir_type;
        logic                   pred;
        logic [31:0]            addr;
    } stage_t;

    typedef struct packed {
        logic        pred;
        logic [31:0] pred_addr;
        logic        active;
        logic        taken;
        logic        jump;
        logic [31:0] jump_addr;
    } expect_t;

    logic        clk;
    logic        i_reset;
    logic        i_stall;
    logic [31:0] i_pc_if;
    logic [31:0] i_ir_if;
    logic        i_ex_taken;
    logic [31:0] i_ex_target;
    logic        o_jump_prediction;
    logic [31:0] o_addr_prediction;
    logic        o_jump;
    logic [31:0] o_jump_addr;

    // Expected table contents, counters coded 0 strong not taken up to 3 strong taken
    logic        m_valid  [ENTRIES];
    logic [31:0] m_tag    [ENTRIES];
    logic [31:0] m_target [ENTRIES];
    logic [1:0]  m_cnt    [ENTRIES];
    stage_t      m_ifid;
    stage_t      m_idex;

    rv_types_pkg::ir_type_e fetch_type;
    logic [31:0]            lfsr = 32'hd3d0f9c2;
    int err_count = 0;
    int check_count = 0;
    int redirect_count = 0;
    int taken_pred_count = 0;

    jump_predict_top #(.INDEX_BITS(INDEX_BITS)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    task automatic drive_cycle();
        logic [2:0] kind;
        logic [2:0] stall_bits;
        logic [1:0] taken_bits;
        kind = 3'(take_bits(3));
        i_pc_if = PC_SET[3'(take_bits(3))];
        case (kind)
            3'd0, 3'd1: begin
                i_ir_if    = {17'h00421, 3'b001, 5'd1, 7'b1100011};
                fetch_type = rv_types_pkg::IR_BRANCH;
            end
            3'd2: begin
                i_ir_if    = {17'h00421, 3'b000, 5'd1, 7'b1101111};
                fetch_type = rv_types_pkg::IR_JAL;
            end
            3'd3: begin
                i_ir_if    = {17'h00421, 3'b000, 5'd1, 7'b1100111};
                fetch_type = rv_types_pkg::IR_JALR;
            end
            3'd4: begin
                i_ir_if    = {17'h00421, 3'b000, 5'd1, 7'b0110011};
                fetch_type = rv_types_pkg::IR_OTHER;
            end
            3'd5: begin
                i_ir_if    = {17'h00421, 3'b010, 5'd1, 7'b0000011};
                fetch_type = rv_types_pkg::IR_OTHER;
            end
            3'd6: begin
                // Custom opcode space
                i_ir_if    = {17'h00421, 3'b000, 5'd1, 7'b0001011};
                fetch_type = rv_types_pkg::IR_ILLEGAL;
            end
            default: begin
                i_ir_if    = {17'h00421, 3'b010, 5'd1, 7'b1100111};
                fetch_type = rv_types_pkg::IR_ILLEGAL;
            end
        endcase
        taken_bits  = 2'(take_bits(2));
        i_ex_taken  = (taken_bits != 2'b00);
        i_ex_target = TARGET_SET[2'(take_bits(2))];
        stall_bits  = 3'(take_bits(3));
        i_stall     = (stall_bits == 3'b000);
    endtask

    function automatic expect_t reference(input logic [31:0] pc,
                                          input rv_types_pkg::ir_type_e ir_type,
                                          input logic stall, input logic ex_taken,
                                          input logic [31:0] ex_target);
        expect_t               e;
        logic [INDEX_BITS-1:0] idx;
        logic                  hit;
        logic                  is_branch;
        idx = pc[2 +: INDEX_BITS];
        hit = m_valid[idx] && (m_tag[idx] == (pc >> (2 + INDEX_BITS)));
        case (ir_type)
            rv_types_pkg::IR_JAL, rv_types_pkg::IR_JALR: e.pred = hit;
            rv_types_pkg::IR_BRANCH: e.pred = hit && m_cnt[idx][1];
            default: e.pred = 1'b0;
        endcase
        e.pred_addr = e.pred ? m_target[idx] : pc + 32'd4;
        is_branch = (m_idex.ir_type == rv_types_pkg::IR_BRANCH);
        e.active = m_idex.valid && !stall && (is_branch
            || m_idex.ir_type == rv_types_pkg::IR_JAL || m_idex.ir_type == rv_types_pkg::IR_JALR);
        e.taken = is_branch ? ex_taken : 1'b1;
        e.jump = e.active && ((e.taken != m_idex.pred)
            || (e.taken && m_idex.pred && ex_target != m_idex.addr));
        e.jump_addr = e.taken ? ex_target : m_idex.pc4;
        return e;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
            m_cnt[i]    = 2'd1;
        end
        m_ifid = '0;
        m_idex = '0;
    endtask

    // State after the coming clock edge
    task automatic advance_model(input expect_t e);
        logic [INDEX_BITS-1:0] idx;
        idx = m_idex.pc[2 +: INDEX_BITS];
        if (e.active && m_idex.ir_type == rv_types_pkg::IR_BRANCH) begin
            if (e.taken && m_cnt[idx] != 2'd3) begin
                m_cnt[idx] = m_cnt[idx] + 2'd1;
            end else if (!e.taken && m_cnt[idx] != 2'd0) begin
                m_cnt[idx] = m_cnt[idx] - 2'd1;
            end
        end
        if (e.active && e.taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = m_idex.pc >> (2 + INDEX_BITS);
            m_target[idx] = i_ex_target;
        end
        if (!i_stall) begin
            m_idex         = m_ifid;
            m_idex.valid   = m_ifid.valid && !e.jump;
            m_ifid.valid   = !e.jump;
            m_ifid.pc      = i_pc_if;
            m_ifid.pc4     = i_pc_if + 32'd4;
            m_ifid.ir_type = fetch_type;
            m_ifid.pred    = e.pred;
            m_ifid.addr    = e.pred_addr;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Compare on the falling edge, halfway between drive and capture
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            if (i_reset) begin
                reset_model();
            end else begin
                e = reference(i_pc_if, fetch_type, i_stall, i_ex_taken, i_ex_target);
                check_value("o_jump_prediction", 32'(o_jump_prediction), 32'(e.pred));
                check_value("o_addr_prediction", o_addr_prediction, e.pred_addr);
                check_value("o_jump", 32'(o_jump), 32'(e.jump));
                check_value("update_valid", 32'(uut.upd_if.update_valid), 32'(e.active));
                if (e.jump) begin
                    check_value("o_jump_addr", o_jump_addr, e.jump_addr);
                    redirect_count++;
                end
                if (e.pred) begin
                    taken_pred_count++;
                end
                advance_model(e);
            end
        end
    end

    initial begin
        i_reset     = 1'b1;
        i_stall     = 1'b0;
        i_pc_if     = '0;
        i_ir_if     = 32'h0000_0013;
        i_ex_taken  = 1'b0;
        i_ex_target = '0;
        fetch_type  = rv_types_pkg::IR_OTHER;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        repeat (TEST_CYCLES) begin
            drive_cycle();
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(negedge clk);
        #1;
        if (redirect_count == 0 || taken_pred_count == 0) begin
            err_count++;
            $display("Stimulus never produced both a taken prediction and a redirect");
        end
        $display("Checks: %0d, errors: %0d, redirects: %0d, taken predictions: %0d",
                 check_count, err_count, redirect_count, taken_pred_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES + 10) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("** FAIL **");
        $finish;
    end

endmodule
